// ==== hdl/mmio_config.svh ====
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// i/o regions, everything else falls through to ram
`define MMIO_UART_BASE      32'hF000_0000
`define MMIO_TIMER_BASE     32'hF000_0100

// each i/o region is four words wide
`define MMIO_REGION_BYTES   32'h0000_0010

// ram size in 32-bit words, the address wraps modulo this
`define MMIO_RAM_WORDS      1024

// uart bit time in clocks
`define MMIO_CLKS_PER_BIT   8

`endif

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    // byte address as issued by the bus master
    typedef logic [31:0] addr_t;

    // one bus data word
    typedef logic [31:0] data_t;

    // which target owns a command
    typedef logic [1:0] target_t;

    localparam target_t TGT_RAM   = 2'd0;
    localparam target_t TGT_UART  = 2'd1;
    localparam target_t TGT_TIMER = 2'd2;

endpackage

// ==== hdl/periph_pkg.sv ====
package periph_pkg;

    // 8N1 transmitter phases
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_e;

    // mtime and mtimecmp width
    typedef logic [63:0] mtime_t;

    // completed uart frames
    typedef logic [15:0] byte_cnt_t;

endpackage

// ==== hdl/mmio_decoder.sv ====
`timescale 1ns/10ps

`include "mmio_config.svh"

module mmio_decoder (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              cmd_start,
    input  logic              cmd_write,
    input  bus_pkg::addr_t    cmd_addr,
    input  bus_pkg::data_t    cmd_wdata,
    output logic              cmd_ready,
    output bus_pkg::data_t    rdata,
    output logic              rdata_valid,

    output logic              ram_start,
    output logic              ram_write,
    output bus_pkg::addr_t    ram_addr,
    output bus_pkg::data_t    ram_wdata,
    input  logic              ram_ready,
    input  bus_pkg::data_t    ram_rdata,
    input  logic              ram_rdata_valid,

    output logic              uart_start,
    output logic              uart_write,
    output bus_pkg::addr_t    uart_addr,
    output bus_pkg::data_t    uart_wdata,
    input  logic              uart_ready,
    input  bus_pkg::data_t    uart_rdata,
    input  logic              uart_rdata_valid,

    output logic              timer_start,
    output logic              timer_write,
    output bus_pkg::addr_t    timer_addr,
    output bus_pkg::data_t    timer_wdata,
    input  logic              timer_ready,
    input  bus_pkg::data_t    timer_rdata,
    input  logic              timer_rdata_valid
);

    logic              in_uart;
    logic              in_timer;
    logic              accept;
    bus_pkg::target_t  live_target;
    bus_pkg::target_t  held_target;

    // decode on the live address
    assign in_uart  = (cmd_addr >= `MMIO_UART_BASE) &&
                      (cmd_addr < (`MMIO_UART_BASE + `MMIO_REGION_BYTES));
    assign in_timer = (cmd_addr >= `MMIO_TIMER_BASE) &&
                      (cmd_addr < (`MMIO_TIMER_BASE + `MMIO_REGION_BYTES));

    always_comb begin
        if (in_uart) begin
            live_target = bus_pkg::TGT_UART;
        end else if (in_timer) begin
            live_target = bus_pkg::TGT_TIMER;
        end else begin
            live_target = bus_pkg::TGT_RAM;
        end
    end

    assign accept = cmd_start && cmd_ready;

    // only the addressed target sees start and write
    assign ram_start   = accept && (live_target == bus_pkg::TGT_RAM);
    assign ram_write   = cmd_write && (live_target == bus_pkg::TGT_RAM);
    assign uart_start  = accept && (live_target == bus_pkg::TGT_UART);
    assign uart_write  = cmd_write && (live_target == bus_pkg::TGT_UART);
    assign timer_start = accept && (live_target == bus_pkg::TGT_TIMER);
    assign timer_write = cmd_write && (live_target == bus_pkg::TGT_TIMER);

    // i/o targets get region-relative offsets
    assign ram_addr    = cmd_addr;
    assign uart_addr   = cmd_addr - `MMIO_UART_BASE;
    assign timer_addr  = cmd_addr - `MMIO_TIMER_BASE;

    assign ram_wdata   = cmd_wdata;
    assign uart_wdata  = cmd_wdata;
    assign timer_wdata = cmd_wdata;

    // target of the last accepted command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_target <= bus_pkg::TGT_RAM;
        end else if (accept) begin
            held_target <= live_target;
        end
    end

    // all result signals come from the held target
    always_comb begin
        case (held_target)
            bus_pkg::TGT_UART: begin
                cmd_ready   = uart_ready;
                rdata       = uart_rdata;
                rdata_valid = uart_rdata_valid;
            end
            bus_pkg::TGT_TIMER: begin
                cmd_ready   = timer_ready;
                rdata       = timer_rdata;
                rdata_valid = timer_rdata_valid;
            end
            default: begin
                cmd_ready   = ram_ready;
                rdata       = ram_rdata;
                rdata_valid = ram_rdata_valid;
            end
        endcase
    end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/10ps

`include "mmio_config.svh"

module data_ram (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            write,
    input  bus_pkg::addr_t  addr,
    input  bus_pkg::data_t  wdata,
    output logic            ready,
    output bus_pkg::data_t  rdata,
    output logic            rdata_valid
);

    localparam int WORDS   = `MMIO_RAM_WORDS;
    localparam int INDEX_W = $clog2(WORDS);

    bus_pkg::data_t      mem [WORDS];
    logic [INDEX_W-1:0]  word_idx;

    // high address bits are ignored, so the ram aliases
    assign word_idx = addr[INDEX_W+1:2];

    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (start && write) begin
            mem[word_idx] <= wdata;
        end
    end

    // registered read, data one cycle after start
    always_ff @(posedge clk) begin
        if (start && !write) begin
            rdata <= mem[word_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= start && !write;
        end
    end

endmodule

// ==== hdl/uart_tx_port.sv ====
`timescale 1ns/10ps

`include "mmio_config.svh"

module uart_tx_port (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            write,
    input  bus_pkg::addr_t  addr,
    input  bus_pkg::data_t  wdata,
    output logic            ready,
    output bus_pkg::data_t  rdata,
    output logic            rdata_valid,
    output logic            uart_tx
);

    localparam int CLKS_PER_BIT = `MMIO_CLKS_PER_BIT;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

    periph_pkg::uart_state_e  state_q;
    periph_pkg::byte_cnt_t    sent_cnt_q;
    logic [CLK_CNT_W-1:0]     clk_cnt_q;
    logic [2:0]               bit_idx_q;
    logic [7:0]               shift_q;
    logic                     bit_end;
    logic                     load;
    logic                     data_reg_hit;

    assign data_reg_hit = (addr[3:0] == 4'h0);
    assign bit_end      = (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1));
    assign load         = start && write && data_reg_hit &&
                          (state_q == periph_pkg::UART_IDLE);

    // busy from the cycle after the write until the stop bit is done
    assign ready = (state_q == periph_pkg::UART_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= periph_pkg::UART_IDLE;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            sent_cnt_q <= '0;
        end else begin
            if (state_q == periph_pkg::UART_IDLE || bit_end) begin
                clk_cnt_q <= '0;
            end else begin
                clk_cnt_q <= clk_cnt_q + 1'b1;
            end
            case (state_q)
                periph_pkg::UART_IDLE: begin
                    if (load) begin
                        state_q <= periph_pkg::UART_START;
                    end
                end
                periph_pkg::UART_START: begin
                    if (bit_end) begin
                        state_q   <= periph_pkg::UART_DATA;
                        bit_idx_q <= '0;
                    end
                end
                periph_pkg::UART_DATA: begin
                    if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= periph_pkg::UART_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q    <= periph_pkg::UART_IDLE;
                        sent_cnt_q <= sent_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb goes out first
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= wdata[7:0];
        end else if (state_q == periph_pkg::UART_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state_q)
            periph_pkg::UART_START: uart_tx = 1'b0;
            periph_pkg::UART_DATA:  uart_tx = shift_q[0];
            default:                uart_tx = 1'b1;
        endcase
    end

    // read returns the frame count, other offsets read zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= start && !write;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !write) begin
            rdata <= data_reg_hit ? bus_pkg::data_t'(sent_cnt_q) : '0;
        end
    end

endmodule

// ==== hdl/machine_timer.sv ====
`timescale 1ns/10ps

module machine_timer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            write,
    input  bus_pkg::addr_t  addr,
    input  bus_pkg::data_t  wdata,
    output logic            ready,
    output bus_pkg::data_t  rdata,
    output logic            rdata_valid,
    output logic            timer_irq
);

    periph_pkg::mtime_t  mtime_q;
    periph_pkg::mtime_t  mtimecmp_q;
    logic [1:0]          word_sel;

    // word offset within the region
    assign word_sel = addr[3:2];

    // single-cycle target, never stalls
    assign ready = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // mtime is read-only, writes to offsets 0x0 and 0x4 are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '1;
        end else if (start && write) begin
            case (word_sel)
                2'd2:    mtimecmp_q[31:0]  <= wdata;
                2'd3:    mtimecmp_q[63:32] <= wdata;
                default: mtimecmp_q        <= mtimecmp_q;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime_q >= mtimecmp_q);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= start && !write;
        end
    end

    // value sampled in the accept cycle
    always_ff @(posedge clk) begin
        if (start && !write) begin
            case (word_sel)
                2'd0:    rdata <= mtime_q[31:0];
                2'd1:    rdata <= mtime_q[63:32];
                2'd2:    rdata <= mtimecmp_q[31:0];
                default: rdata <= mtimecmp_q[63:32];
            endcase
        end
    end

endmodule

// ==== hdl/mmio_sys.sv ====
`timescale 1ns/10ps

module mmio_sys (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_start,
    input  logic            cmd_write,
    input  bus_pkg::addr_t  cmd_addr,
    input  bus_pkg::data_t  cmd_wdata,
    output logic            cmd_ready,
    output bus_pkg::data_t  rdata,
    output logic            rdata_valid,
    output logic            uart_tx,
    output logic            timer_irq
);

    // decoder to ram
    logic            ram_start;
    logic            ram_write;
    bus_pkg::addr_t  ram_addr;
    bus_pkg::data_t  ram_wdata;
    logic            ram_ready;
    bus_pkg::data_t  ram_rdata;
    logic            ram_rdata_valid;

    // decoder to uart
    logic            uart_start;
    logic            uart_write;
    bus_pkg::addr_t  uart_addr;
    bus_pkg::data_t  uart_wdata;
    logic            uart_ready;
    bus_pkg::data_t  uart_rdata;
    logic            uart_rdata_valid;

    // decoder to timer
    logic            timer_start;
    logic            timer_write;
    bus_pkg::addr_t  timer_addr;
    bus_pkg::data_t  timer_wdata;
    logic            timer_ready;
    bus_pkg::data_t  timer_rdata;
    logic            timer_rdata_valid;

    mmio_decoder i_mmio_decoder (
        .clk               (clk),
        .rst_n             (rst_n),
        .cmd_start         (cmd_start),
        .cmd_write         (cmd_write),
        .cmd_addr          (cmd_addr),
        .cmd_wdata         (cmd_wdata),
        .cmd_ready         (cmd_ready),
        .rdata             (rdata),
        .rdata_valid       (rdata_valid),
        .ram_start         (ram_start),
        .ram_write         (ram_write),
        .ram_addr          (ram_addr),
        .ram_wdata         (ram_wdata),
        .ram_ready         (ram_ready),
        .ram_rdata         (ram_rdata),
        .ram_rdata_valid   (ram_rdata_valid),
        .uart_start        (uart_start),
        .uart_write        (uart_write),
        .uart_addr         (uart_addr),
        .uart_wdata        (uart_wdata),
        .uart_ready        (uart_ready),
        .uart_rdata        (uart_rdata),
        .uart_rdata_valid  (uart_rdata_valid),
        .timer_start       (timer_start),
        .timer_write       (timer_write),
        .timer_addr        (timer_addr),
        .timer_wdata       (timer_wdata),
        .timer_ready       (timer_ready),
        .timer_rdata       (timer_rdata),
        .timer_rdata_valid (timer_rdata_valid)
    );

    data_ram i_data_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (ram_start),
        .write       (ram_write),
        .addr        (ram_addr),
        .wdata       (ram_wdata),
        .ready       (ram_ready),
        .rdata       (ram_rdata),
        .rdata_valid (ram_rdata_valid)
    );

    uart_tx_port i_uart_tx_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (uart_start),
        .write       (uart_write),
        .addr        (uart_addr),
        .wdata       (uart_wdata),
        .ready       (uart_ready),
        .rdata       (uart_rdata),
        .rdata_valid (uart_rdata_valid),
        .uart_tx     (uart_tx)
    );

    machine_timer i_machine_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (timer_start),
        .write       (timer_write),
        .addr        (timer_addr),
        .wdata       (timer_wdata),
        .ready       (timer_ready),
        .rdata       (timer_rdata),
        .rdata_valid (timer_rdata_valid),
        .timer_irq   (timer_irq)
    );

endmodule

// ==== verif/mmio_sys_tb.sv ====
`timescale 1ns/10ps

`include "mmio_config.svh"

module mmio_sys_tb;

    localparam int CLKS_PER_BIT = `MMIO_CLKS_PER_BIT;
    localparam int RAM_WORDS    = `MMIO_RAM_WORDS;
    localparam int RAM_TESTS    = 64;
    localparam int UART_BYTES   = 3;
    localparam int IDLE_GAP     = 50;
    localparam int IRQ_WAIT     = 260;
    // full run is under 2000 cycles, so this leaves a wide margin
    localparam int CYCLE_LIMIT  = 20000;

    logic            clk;
    logic            rst_n;
    logic            cmd_start;
    logic            cmd_write;
    bus_pkg::addr_t  cmd_addr;
    bus_pkg::data_t  cmd_wdata;
    logic            cmd_ready;
    bus_pkg::data_t  rdata;
    logic            rdata_valid;
    logic            uart_tx;
    logic            timer_irq;

    int              seed = 14409;
    int              err_cnt;
    int              pass_cnt;
    int              fail_cnt;
    int              cycle_cnt;
    int              frames_seen;
    int              test_errs;
    int              i;
    int              busy;
    int              waited;
    int              rx_bit;
    logic [7:0]      rx_byte;
    logic [7:0]      rx_exp;
    logic [7:0]      tx_byte;
    bus_pkg::addr_t  addr;
    bus_pkg::addr_t  lo_addr;
    bus_pkg::data_t  word;
    bus_pkg::data_t  got;
    bus_pkg::data_t  t0;
    bus_pkg::data_t  t1;
    periph_pkg::mtime_t  now;
    periph_pkg::mtime_t  cmp;

    // shadow copy of the ram contents
    bus_pkg::data_t  shadow [RAM_WORDS];
    bus_pkg::addr_t  ram_addrs [RAM_TESTS];
    logic [7:0]      uart_expect [$];

    mmio_sys i_mmio_sys (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .uart_tx     (uart_tx),
        .timer_irq   (timer_irq)
    );

    always #20 clk = ~clk;

    // word index wraps modulo the ram depth
    function automatic int ram_index(input bus_pkg::addr_t a);
        return int'((a >> 2) % RAM_WORDS);
    endfunction

    function automatic bus_pkg::data_t expected_ram(input bus_pkg::addr_t a);
        return shadow[ram_index(a)];
    endfunction

    task automatic shadow_store(input bus_pkg::addr_t a, input bus_pkg::data_t d);
        shadow[ram_index(a)] = d;
    endtask

    task automatic compare_word(input string what, input bus_pkg::data_t actual,
                                input bus_pkg::data_t exp);
        if (actual !== exp) begin
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, actual, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // inputs change on the falling edge, accept happens on the next rising edge
    task automatic bus_write(input bus_pkg::addr_t a, input bus_pkg::data_t d);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        cmd_start = 1'b1;
        cmd_write = 1'b1;
        cmd_addr  = a;
        cmd_wdata = d;
        @(negedge clk);
        cmd_start = 1'b0;
        cmd_write = 1'b0;
    endtask

    task automatic bus_read(input bus_pkg::addr_t a, output bus_pkg::data_t d);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        cmd_start = 1'b1;
        cmd_write = 1'b0;
        cmd_addr  = a;
        @(negedge clk);
        cmd_start = 1'b0;
        while (!rdata_valid) @(negedge clk);
        d = rdata;
        @(negedge clk);
        if (rdata_valid) begin
            $display("read of %h at %0t gave more than one rdata_valid pulse", a, $time);
            err_cnt++;
        end
    endtask

    // 8N1 receiver, samples near each bit centre
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_tx);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                $display("Mismatch at %0t: uart start bit is %b", $time, uart_tx);
                err_cnt++;
            end
            for (rx_bit = 0; rx_bit < 8; rx_bit++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[rx_bit] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                $display("Mismatch at %0t: uart stop bit is %b", $time, uart_tx);
                err_cnt++;
            end
            if (uart_expect.size() == 0) begin
                $display("uart frame at %0t arrived with no byte expected", $time);
                err_cnt++;
            end else begin
                rx_exp = uart_expect.pop_front();
                if (rx_byte !== rx_exp) begin
                    $display("Mismatch at %0t: uart byte %h, expected %h",
                             $time, rx_byte, rx_exp);
                    err_cnt++;
                end
            end
            frames_seen++;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", CYCLE_LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_start   = 1'b0;
        cmd_write   = 1'b0;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        frames_seen = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_errs = err_cnt;
        @(negedge clk);
        if (cmd_ready !== 1'b1 || rdata_valid !== 1'b0 ||
            uart_tx !== 1'b1 || timer_irq !== 1'b0) begin
            $display("Mismatch at %0t: reset values ready=%b valid=%b tx=%b irq=%b",
                     $time, cmd_ready, rdata_valid, uart_tx, timer_irq);
            err_cnt++;
        end
        finish_test("reset", test_errs);

        test_errs = err_cnt;
        for (i = 0; i < RAM_TESTS; i++) begin
            word = $random(seed);
            addr = {2'b00, word[29:2], 2'b00};
            ram_addrs[i] = addr;
            word = $random(seed);
            bus_write(addr, word);
            shadow_store(addr, word);
        end
        for (i = 0; i < RAM_TESTS; i++) begin
            bus_read(ram_addrs[i], got);
            compare_word("ram", got, expected_ram(ram_addrs[i]));
        end
        finish_test("ram random", test_errs);

        // high address bits outside the i/o regions fold onto the low alias
        test_errs = err_cnt;
        addr    = 32'hF123_4568;
        lo_addr = bus_pkg::addr_t'(ram_index(addr) * 4);
        word    = $random(seed);
        bus_write(addr, word);
        shadow_store(addr, word);
        bus_read(lo_addr, got);
        compare_word("ram low alias", got, expected_ram(lo_addr));
        word = $random(seed);
        bus_write(lo_addr, word);
        shadow_store(lo_addr, word);
        bus_read(addr, got);
        compare_word("ram high alias", got, expected_ram(addr));
        finish_test("ram aliasing", test_errs);

        test_errs = err_cnt;
        for (i = 0; i < UART_BYTES; i++) begin
            word    = $random(seed);
            tx_byte = word[7:0];
            uart_expect.push_back(tx_byte);
            bus_write(`MMIO_UART_BASE, {24'h0, tx_byte});
            busy = 0;
            while (!cmd_ready) begin
                busy++;
                @(negedge clk);
            end
            // one start, eight data and one stop bit
            if (busy != 10 * CLKS_PER_BIT) begin
                $display("Mismatch at %0t: uart busy for %0d cycles, expected %0d",
                         $time, busy, 10 * CLKS_PER_BIT);
                err_cnt++;
            end
        end
        if (frames_seen != UART_BYTES || uart_expect.size() != 0) begin
            $display("uart receiver saw %0d frames, expected %0d", frames_seen, UART_BYTES);
            err_cnt++;
        end
        bus_read(`MMIO_UART_BASE, got);
        compare_word("uart byte count", got, bus_pkg::data_t'(UART_BYTES));
        finish_test("uart", test_errs);

        test_errs = err_cnt;
        bus_read(`MMIO_TIMER_BASE, t0);
        repeat (IDLE_GAP) @(negedge clk);
        bus_read(`MMIO_TIMER_BASE, t1);
        if ((t1 - t0) < bus_pkg::data_t'(IDLE_GAP)) begin
            $display("Mismatch at %0t: mtime moved %0d over %0d idle cycles",
                     $time, t1 - t0, IDLE_GAP);
            err_cnt++;
        end
        bus_read(`MMIO_TIMER_BASE, t0);
        bus_read(`MMIO_TIMER_BASE + 32'h4, t1);
        now = {t1, t0};
        cmp = now + 64'd200;
        bus_write(`MMIO_TIMER_BASE + 32'hC, cmp[63:32]);
        bus_write(`MMIO_TIMER_BASE + 32'h8, cmp[31:0]);
        if (timer_irq !== 1'b0) begin
            $display("Mismatch at %0t: timer_irq high right after mtimecmp write", $time);
            err_cnt++;
        end
        waited = 0;
        while (!timer_irq && waited < IRQ_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!timer_irq) begin
            $display("timer_irq did not rise within %0d cycles", IRQ_WAIT);
            err_cnt++;
        end
        bus_read(`MMIO_TIMER_BASE + 32'h8, got);
        compare_word("mtimecmp low", got, cmp[31:0]);
        bus_read(`MMIO_TIMER_BASE + 32'hC, got);
        compare_word("mtimecmp high", got, cmp[63:32]);
        finish_test("timer", test_errs);

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== mmio_sys.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/mmio_decoder.sv
hdl/data_ram.sv
hdl/uart_tx_port.sv
hdl/machine_timer.sv
hdl/mmio_sys.sv
verif/mmio_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mmio_sys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    -f mmio_sys.f \
    --top-module mmio_sys_tb \
    -o mmio_sys_sim

./obj_dir/mmio_sys_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished cleanly"
